/* all.f */
+incdir+logic
logic/tpl_adc_pkg.sv
logic/chan_ctrl_if.sv
logic/tpl_adc_deframer.sv
logic/tpl_adc_pn_monitor.sv
logic/tpl_adc_channel.sv
logic/tpl_adc_core.sv
tests/tb_clock.sv
tests/tpl_adc_checker.sv
tests/tb_tpl_adc.sv

/* logic/chan_ctrl_if.sv */
`timescale 1ns/1ps

interface chan_ctrl_if;

  // Data format controls, static levels from the register side
  logic dfmt_enable;
  logic dfmt_sign_extend;
  logic dfmt_type;

  // PN sequence the channel is expected to carry
  tpl_adc_pkg::pn_sel_e pn_seq_sel;

  // PN status, updated once per valid beat
  logic pn_err;
  logic pn_oos;

  // Control side, drives the settings and collects the status
  modport ctrl (
    output dfmt_enable,
    output dfmt_sign_extend,
    output dfmt_type,
    output pn_seq_sel,
    input  pn_err,
    input  pn_oos
  );

  // Channel side, uses the settings and reports the status
  modport chan (
    input  dfmt_enable,
    input  dfmt_sign_extend,
    input  dfmt_type,
    input  pn_seq_sel,
    output pn_err,
    output pn_oos
  );

endinterface

/* logic/tpl_adc_cfg.svh */
`ifndef TPL_ADC_CFG_SVH
`define TPL_ADC_CFG_SVH

// Link geometry, two lanes with four octets per lane on every beat
`define TPL_NUM_LANES 2
`define TPL_OCTETS_PER_BEAT 4

// One converter sits behind each lane
`define TPL_NUM_CHANNELS 2

// Converter resolution and the width of a sample on the link and to DMA
`define TPL_RESOLUTION 14
`define TPL_SAMPLE_BITS 16
`define TPL_SAMPLES_PER_BEAT 2

// Consecutive good or bad beats needed to change the PN out-of-sync state
`define TPL_PN_LOCK_COUNT 16

// Derived bus widths
`define TPL_LINK_WIDTH (`TPL_NUM_LANES * `TPL_OCTETS_PER_BEAT * 8)
`define TPL_DMA_WIDTH (`TPL_NUM_CHANNELS * `TPL_SAMPLES_PER_BEAT * `TPL_SAMPLE_BITS)

`endif

/* logic/tpl_adc_channel.sv */
`timescale 1ns/1ps
`include "tpl_adc_cfg.svh"

module tpl_adc_channel (
  input  logic clk,
  input  logic arst_n,
  input  logic beat_valid,
  input  tpl_adc_pkg::raw_sample_t [`TPL_SAMPLES_PER_BEAT-1:0] raw_data,
  output tpl_adc_pkg::fmt_sample_t [`TPL_SAMPLES_PER_BEAT-1:0] fmt_data,
  chan_ctrl_if.chan ctrl
);

  localparam int NUM_SMP = `TPL_SAMPLES_PER_BEAT;
  localparam int RES = `TPL_RESOLUTION;
  localparam int EXT = `TPL_SAMPLE_BITS - `TPL_RESOLUTION;

  tpl_adc_pkg::fmt_sample_t [NUM_SMP-1:0] fmt_next;

  // *************************************************************************
  // Data formatter
  // *************************************************************************

  always_comb begin
    logic msb;
    logic ext_bit;

    msb = 1'b0;
    ext_bit = 1'b0;
    fmt_next = '0;
    for (int n = 0; n < NUM_SMP; n++) begin
      // Offset binary input gets its MSB flipped to become two's complement
      msb = raw_data[n][RES-1] ^ ~ctrl.dfmt_type;
      ext_bit = ctrl.dfmt_sign_extend & msb;
      if (ctrl.dfmt_enable) begin
        fmt_next[n] = {{EXT{ext_bit}}, msb, raw_data[n][RES-2:0]};
      end else begin
        // Formatter bypassed, converter code is passed as it is
        fmt_next[n] = {{EXT{1'b0}}, raw_data[n]};
      end
    end
  end

  // Output register, second stage of the data path
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fmt_data <= '0;
    end else begin
      fmt_data <= fmt_next;
    end
  end

  // *************************************************************************
  // PN monitor
  // *************************************************************************

  // Checks the raw samples, so the result does not depend on formatting
  tpl_adc_pn_monitor i_pn_monitor (
    .clk        (clk),
    .arst_n     (arst_n),
    .beat_valid (beat_valid),
    .samples    (raw_data),
    .pn_seq_sel (ctrl.pn_seq_sel),
    .pn_err     (ctrl.pn_err),
    .pn_oos     (ctrl.pn_oos)
  );

endmodule

/* logic/tpl_adc_core.sv */
`timescale 1ns/1ps
`include "tpl_adc_cfg.svh"

module tpl_adc_core (
  input  logic clk,
  input  logic arst_n,

  // JESD204 link side
  input  logic link_valid,
  input  logic [`TPL_LINK_WIDTH-1:0] link_data,

  // Sync arming
  input  logic adc_sync,
  input  logic adc_sync_in,
  output logic adc_sync_armed,

  // Per-channel controls
  input  logic [`TPL_NUM_CHANNELS-1:0] dfmt_enable,
  input  logic [`TPL_NUM_CHANNELS-1:0] dfmt_sign_extend,
  input  logic [`TPL_NUM_CHANNELS-1:0] dfmt_type,
  input  logic [4*`TPL_NUM_CHANNELS-1:0] pn_seq_sel,

  // DMA side and PN status
  output logic [`TPL_NUM_CHANNELS-1:0] adc_valid,
  output logic [`TPL_DMA_WIDTH-1:0] adc_data,
  output logic [`TPL_NUM_CHANNELS-1:0] pn_err,
  output logic [`TPL_NUM_CHANNELS-1:0] pn_oos
);

  localparam int NUM_CH = `TPL_NUM_CHANNELS;
  localparam int CH_BITS = `TPL_SAMPLES_PER_BEAT * `TPL_SAMPLE_BITS;

  tpl_adc_pkg::raw_sample_t [NUM_CH-1:0][`TPL_SAMPLES_PER_BEAT-1:0] raw_data;
  logic valid_d1;
  logic valid_d2;
  logic sync_d1;
  logic sync_in_d1;

  // *************************************************************************
  // Sync arming
  // *************************************************************************

  // A rising edge on adc_sync toggles the flag, a rising edge on
  // adc_sync_in (the sync coming back from the link) clears it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_d1 <= 1'b0;
      sync_in_d1 <= 1'b0;
      adc_sync_armed <= 1'b0;
    end else begin
      sync_d1 <= adc_sync;
      sync_in_d1 <= adc_sync_in;
      if (adc_sync && !sync_d1) begin
        adc_sync_armed <= ~adc_sync_armed;
      end else if (adc_sync_in && !sync_in_d1) begin
        adc_sync_armed <= 1'b0;
      end
    end
  end

  // Valid follows the two register stages of the data path
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_d1 <= 1'b0;
      valid_d2 <= 1'b0;
    end else begin
      valid_d1 <= link_valid;
      valid_d2 <= valid_d1;
    end
  end

  assign adc_valid = {NUM_CH{valid_d2}};

  // *************************************************************************
  // Data path
  // *************************************************************************

  tpl_adc_deframer i_deframer (
    .clk       (clk),
    .arst_n    (arst_n),
    .link_data (link_data),
    .raw_data  (raw_data)
  );

  for (genvar i = 0; i < NUM_CH; i++) begin : g_channel
    chan_ctrl_if i_ctrl ();

    // Register side settings go onto the channel interface
    assign i_ctrl.dfmt_enable = dfmt_enable[i];
    assign i_ctrl.dfmt_sign_extend = dfmt_sign_extend[i];
    assign i_ctrl.dfmt_type = dfmt_type[i];
    assign i_ctrl.pn_seq_sel = tpl_adc_pkg::pn_sel_e'(pn_seq_sel[4*i +: 4]);
    assign pn_err[i] = i_ctrl.pn_err;
    assign pn_oos[i] = i_ctrl.pn_oos;

    // Raw data is one cycle behind the link, so is valid_d1
    tpl_adc_channel i_channel (
      .clk        (clk),
      .arst_n     (arst_n),
      .beat_valid (valid_d1),
      .raw_data   (raw_data[i]),
      .fmt_data   (adc_data[CH_BITS*i +: CH_BITS]),
      .ctrl       (i_ctrl.chan)
    );
  end

endmodule

/* logic/tpl_adc_deframer.sv */
`timescale 1ns/1ps
`include "tpl_adc_cfg.svh"

module tpl_adc_deframer (
  input  logic clk,
  input  logic arst_n,
  input  logic [`TPL_LINK_WIDTH-1:0] link_data,
  output tpl_adc_pkg::raw_sample_t [`TPL_NUM_CHANNELS-1:0][`TPL_SAMPLES_PER_BEAT-1:0] raw_data
);

  localparam int NUM_CH = `TPL_NUM_CHANNELS;
  localparam int NUM_SMP = `TPL_SAMPLES_PER_BEAT;
  localparam int SMP_BITS = `TPL_SAMPLE_BITS;
  localparam int RES = `TPL_RESOLUTION;
  localparam int LANE_BITS = `TPL_OCTETS_PER_BEAT * 8;
  localparam int OCTETS_PER_SAMPLE = SMP_BITS / 8;

  tpl_adc_pkg::raw_sample_t [NUM_CH-1:0][NUM_SMP-1:0] raw_next;

  // *************************************************************************
  // Octet reordering
  // *************************************************************************

  // The link sends octets in transmission order, octet 0 first and in the
  // lowest byte of the lane, while a sample is sent high byte first
  // So every sample word has to be rebuilt by swapping its octets around
  always_comb begin
    logic [SMP_BITS-1:0] word;

    word = '0;
    raw_next = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      // Lane c feeds converter c, no interleaving between lanes
      for (int n = 0; n < NUM_SMP; n++) begin
        for (int b = 0; b < OCTETS_PER_SAMPLE; b++) begin
          // Earlier octet of the sample goes to the more significant byte
          word[SMP_BITS-1-8*b -: 8] =
            link_data[c*LANE_BITS + 8*(n*OCTETS_PER_SAMPLE + b) +: 8];
        end
        // Converter bits are left aligned in the sample word
        // The bits below them are control/tail bits and get dropped
        raw_next[c][n] = word[SMP_BITS-1 -: RES];
      end
    end
  end

  // *************************************************************************
  // Output register
  // *************************************************************************

  // Loads on every cycle, the valid pipeline in the core qualifies it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      raw_data <= '0;
    end else begin
      raw_data <= raw_next;
    end
  end

endmodule

/* logic/tpl_adc_pkg.sv */
`include "tpl_adc_cfg.svh"

package tpl_adc_pkg;

  // *************************************************************************
  // Sample types
  // *************************************************************************

  // Converter sample as it comes off the link, tail bits already removed
  typedef logic [`TPL_RESOLUTION-1:0] raw_sample_t;

  // Sample after data formatting, this is what the DMA sees
  typedef logic [`TPL_SAMPLE_BITS-1:0] fmt_sample_t;

  // *************************************************************************
  // PN test sequence selection
  // *************************************************************************

  // Encoding follows the usual register map of the ADC channel
  // Codes that are not listed here disable the monitor
  typedef enum logic [3:0] {
    PN_OFF = 4'h0,
    PN7    = 4'h4,
    PN15   = 4'h5
  } pn_sel_e;

endpackage

/* logic/tpl_adc_pn_monitor.sv */
`timescale 1ns/1ps
`include "tpl_adc_cfg.svh"

module tpl_adc_pn_monitor (
  input  logic clk,
  input  logic arst_n,
  input  logic beat_valid,
  input  tpl_adc_pkg::raw_sample_t [`TPL_SAMPLES_PER_BEAT-1:0] samples,
  input  tpl_adc_pkg::pn_sel_e pn_seq_sel,
  output logic pn_err,
  output logic pn_oos
);

  localparam int NUM_SMP = `TPL_SAMPLES_PER_BEAT;
  localparam int RES = `TPL_RESOLUTION;
  localparam int CNT_W = $clog2(`TPL_PN_LOCK_COUNT);

  // Work out the sample that should follow prev in the selected sequence
  // The sample is a window of the LFSR output stream with its MSB being
  // the oldest bit, so the window is shifted on by RES new bits
  // A 14-bit window is one bit short of the PN15 register, the missing
  // oldest bit is rebuilt from the parity of the window
  function automatic tpl_adc_pkg::raw_sample_t pn_predict(
    input tpl_adc_pkg::raw_sample_t prev,
    input logic use_pn15
  );
    logic [RES:0] hist;
    logic new_bit;

    hist = {^prev, prev};
    for (int i = 0; i < RES; i++) begin
      if (use_pn15) begin
        // x^15 + x^14 + 1
        new_bit = hist[14] ^ hist[13];
      end else begin
        // x^7 + x^6 + 1
        new_bit = hist[6] ^ hist[5];
      end
      hist = {hist[RES-1:0], new_bit};
    end
    return hist[RES-1:0];
  endfunction

  tpl_adc_pkg::raw_sample_t last_sample;
  tpl_adc_pkg::raw_sample_t [NUM_SMP-1:0] pred;
  logic pn_active;
  logic use_pn15;
  logic mismatch;
  logic [CNT_W-1:0] lock_cnt;

  assign use_pn15 = (pn_seq_sel == tpl_adc_pkg::PN15);
  assign pn_active = (pn_seq_sel == tpl_adc_pkg::PN7) || use_pn15;

  // Predecessor of each sample, sample 0 looks back into the last beat
  assign pred = {samples[NUM_SMP-2:0], last_sample};

  always_comb begin
    mismatch = 1'b0;
    for (int n = 0; n < NUM_SMP; n++) begin
      if (samples[n] != pn_predict(pred[n], use_pn15)) begin
        mismatch = 1'b1;
      end
    end
  end

  // *************************************************************************
  // Error and lock tracking
  // *************************************************************************

  // Last sample of every valid beat seeds the check of the next beat,
  // also while the monitor is off so that it can lock right away
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      last_sample <= '0;
    end else if (beat_valid) begin
      last_sample <= samples[NUM_SMP-1];
    end
  end

  // The counter only runs while the beat result disagrees with the
  // current sync state and starts over on the first beat that agrees
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pn_err <= 1'b0;
      pn_oos <= 1'b1;
      lock_cnt <= '0;
    end else if (!pn_active) begin
      pn_err <= 1'b0;
      pn_oos <= 1'b1;
      lock_cnt <= '0;
    end else if (beat_valid) begin
      pn_err <= mismatch;
      if (pn_oos != mismatch) begin
        if (lock_cnt == CNT_W'(`TPL_PN_LOCK_COUNT - 1)) begin
          // Enough beats in a row, flip the sync state
          pn_oos <= ~pn_oos;
          lock_cnt <= '0;
        end else begin
          lock_cnt <= lock_cnt + 1'b1;
        end
      end else begin
        lock_cnt <= '0;
      end
    end
  end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic arst_n
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // Reset is held for four rising edges and released on the fourth
  initial begin
    arst_n = 1'b0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

/* tests/tb_tpl_adc.sv */
`timescale 1ns/1ps
`include "tpl_adc_cfg.svh"

module tb_tpl_adc;

  localparam int NUM_CH = `TPL_NUM_CHANNELS;
  localparam int NUM_SMP = `TPL_SAMPLES_PER_BEAT;
  localparam int LANE_BITS = `TPL_OCTETS_PER_BEAT * 8;
  // Six tests of at most about 250 cycles each plus margin
  localparam int MAX_CYCLES = 2000;

  logic clk;
  logic arst_n;
  logic link_valid;
  logic [`TPL_LINK_WIDTH-1:0] link_data;
  logic adc_sync;
  logic adc_sync_in;
  logic [NUM_CH-1:0] dfmt_enable;
  logic [NUM_CH-1:0] dfmt_sign_extend;
  logic [NUM_CH-1:0] dfmt_type;
  logic [4*NUM_CH-1:0] pn_seq_sel;
  logic [NUM_CH-1:0] adc_valid;
  logic [`TPL_DMA_WIDTH-1:0] adc_data;
  logic [NUM_CH-1:0] pn_err;
  logic [NUM_CH-1:0] pn_oos;
  logic adc_sync_armed;

  // Current position of the PN stream of each channel
  tpl_adc_pkg::raw_sample_t pn_state [NUM_CH];
  int cycles = 0;
  int err_mark = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  tb_clock i_clock (.clk (clk), .arst_n (arst_n));
  tpl_adc_core i_dut (.*);
  tpl_adc_checker i_checker (.*);

  // Builds a link beat from converter codes with random tail bits
  function automatic logic [`TPL_LINK_WIDTH-1:0] pack_beat(
    input tpl_adc_pkg::raw_sample_t [NUM_CH-1:0][NUM_SMP-1:0] smp
  );
    logic [`TPL_LINK_WIDTH-1:0] d;
    logic [15:0] word;
    logic [31:0] rnd;

    d = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      for (int n = 0; n < NUM_SMP; n++) begin
        rnd = $urandom;
        word = {smp[c][n], rnd[1:0]};
        d[c*LANE_BITS + 16*n +: 8] = word[15:8];
        d[c*LANE_BITS + 16*n + 8 +: 8] = word[7:0];
      end
    end
    return d;
  endfunction

  task automatic drive_beat(input logic [`TPL_LINK_WIDTH-1:0] d);
    @(posedge clk);
    link_valid <= 1'b1;
    link_data <= d;
  endtask

  // Data keeps changing on idle cycles so that stale words would show
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      link_valid <= 1'b0;
      link_data <= {$urandom, $urandom};
    end
  endtask

  task automatic random_beats(input int n, input logic gaps);
    for (int b = 0; b < n; b++) begin
      if (gaps && $urandom_range(0, 2) == 0)
        idle_cycles($urandom_range(1, 3));
      drive_beat({$urandom, $urandom});
    end
  endtask

  // Channel 0 carries PN7 and channel 1 PN15
  // The beat at index bad_beat gets its last sample corrupted on each channel
  task automatic pn_beats(input int n, input int bad_beat);
    tpl_adc_pkg::raw_sample_t [NUM_CH-1:0][NUM_SMP-1:0] smp;

    for (int b = 0; b < n; b++) begin
      for (int c = 0; c < NUM_CH; c++) begin
        for (int s = 0; s < NUM_SMP; s++) begin
          pn_state[c] = i_checker.pn_next(pn_state[c], c == 1);
          smp[c][s] = pn_state[c];
        end
        if (b == bad_beat)
          smp[c][NUM_SMP-1][0] = ~smp[c][NUM_SMP-1][0];
      end
      drive_beat(pack_beat(smp));
    end
  endtask

  task automatic sync_pulse(input logic s, input logic s_in, input logic exp_armed);
    @(posedge clk);
    adc_sync <= s;
    adc_sync_in <= s_in;
    repeat (2) @(posedge clk);
    @(negedge clk);
    i_checker.check_val("adc_sync_armed", exp_armed, adc_sync_armed);
    @(posedge clk);
    adc_sync <= 1'b0;
    adc_sync_in <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  // Lets the pipeline drain and reports the errors seen since the last test
  task automatic finish_test(input string name);
    int errs;

    idle_cycles(4);
    errs = i_checker.n_errors - err_mark;
    err_mark = i_checker.n_errors;
    if (errs == 0) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errs);
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    logic [1:0] mode;

    void'($urandom(99718));
    link_valid = 1'b0;
    link_data = '0;
    adc_sync = 1'b0;
    adc_sync_in = 1'b0;
    dfmt_enable = '0;
    dfmt_sign_extend = '0;
    dfmt_type = '0;
    pn_seq_sel = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      pn_state[c] = $urandom_range(1, 16383);
    end

    wait (arst_n === 1'b1);
    idle_cycles(2);
    @(negedge clk);
    i_checker.check_val("adc_valid", '0, adc_valid);
    i_checker.check_val("pn_err", '0, pn_err);
    i_checker.check_val("pn_oos", {NUM_CH{1'b1}}, pn_oos);
    i_checker.check_val("adc_sync_armed", '0, adc_sync_armed);
    finish_test("reset state");

    random_beats(40, 1'b1);
    finish_test("raw pass-through and latency");

    // Channel 1 always runs the complement of the channel 0 setting
    for (int k = 0; k < 4; k++) begin
      mode = k[1:0];
      @(posedge clk);
      link_valid <= 1'b0;
      dfmt_enable <= '1;
      dfmt_type <= {~mode[0], mode[0]};
      dfmt_sign_extend <= {~mode[1], mode[1]};
      random_beats(12, 1'b1);
    end
    finish_test("formatting modes");

    @(posedge clk);
    link_valid <= 1'b0;
    pn_seq_sel <= {tpl_adc_pkg::PN15, tpl_adc_pkg::PN7};
    idle_cycles(2);
    pn_beats(20, -1);
    idle_cycles(3);
    @(negedge clk);
    i_checker.check_val("pn_oos", '0, pn_oos);
    finish_test("PN lock");

    pn_beats(4, -1);
    pn_beats(1, 0);
    pn_beats(6, -1);
    idle_cycles(3);
    @(negedge clk);
    i_checker.check_val("pn_oos", '0, pn_oos);
    random_beats(16, 1'b0);
    idle_cycles(3);
    @(negedge clk);
    i_checker.check_val("pn_oos", {NUM_CH{1'b1}}, pn_oos);
    finish_test("PN error and loss of sync");

    sync_pulse(1'b1, 1'b0, 1'b1);
    sync_pulse(1'b1, 1'b0, 1'b0);
    sync_pulse(1'b1, 1'b0, 1'b1);
    sync_pulse(1'b0, 1'b1, 1'b0);
    sync_pulse(1'b1, 1'b1, 1'b1);
    sync_pulse(1'b1, 1'b1, 1'b0);
    finish_test("sync arming");

    $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
             tests_passed, tests_failed, i_checker.n_checks, i_checker.n_errors);
    if (tests_failed == 0 && i_checker.n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* tests/tpl_adc_checker.sv */
`timescale 1ns/1ps
`include "tpl_adc_cfg.svh"

module tpl_adc_checker (
  input logic clk,
  input logic arst_n,
  input logic link_valid,
  input logic [`TPL_LINK_WIDTH-1:0] link_data,
  input logic adc_sync,
  input logic adc_sync_in,
  input logic [`TPL_NUM_CHANNELS-1:0] dfmt_enable,
  input logic [`TPL_NUM_CHANNELS-1:0] dfmt_sign_extend,
  input logic [`TPL_NUM_CHANNELS-1:0] dfmt_type,
  input logic [4*`TPL_NUM_CHANNELS-1:0] pn_seq_sel,
  input logic [`TPL_NUM_CHANNELS-1:0] adc_valid,
  input logic [`TPL_DMA_WIDTH-1:0] adc_data,
  input logic [`TPL_NUM_CHANNELS-1:0] pn_err,
  input logic [`TPL_NUM_CHANNELS-1:0] pn_oos,
  input logic adc_sync_armed
);

  localparam int NUM_CH = `TPL_NUM_CHANNELS;
  localparam int NUM_SMP = `TPL_SAMPLES_PER_BEAT;
  localparam int RES = `TPL_RESOLUTION;
  localparam int SMP_BITS = `TPL_SAMPLE_BITS;
  localparam int LANE_BITS = `TPL_OCTETS_PER_BEAT * 8;
  localparam int LOCK = `TPL_PN_LOCK_COUNT;

  // Everything the testbench drives, as seen at one falling edge
  typedef struct packed {
    logic valid;
    logic [`TPL_LINK_WIDTH-1:0] data;
    logic sync;
    logic sync_in;
    logic [NUM_CH-1:0] en;
    logic [NUM_CH-1:0] se;
    logic [NUM_CH-1:0] typ;
    logic [4*NUM_CH-1:0] sel;
  } snap_t;

  int n_checks = 0;
  int n_errors = 0;
  snap_t cur;
  snap_t h1;
  snap_t h2;
  logic exp_armed;
  logic [NUM_CH-1:0] exp_err;
  logic [NUM_CH-1:0] exp_oos;
  tpl_adc_pkg::raw_sample_t last [NUM_CH];
  int good_run [NUM_CH];
  int bad_run [NUM_CH];

  task automatic check_val(input string name, input logic [`TPL_DMA_WIDTH-1:0] exp,
                           input logic [`TPL_DMA_WIDTH-1:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Fail at %0d ns: %s expected %0h, actual %0h", $time, name, exp, act);
    end
  endtask

  // ************************************************************************
  // Reference model
  // ************************************************************************

  // Converter code of sample n on lane c
  // Octet 2n is the high byte of the word and the two tail bits are dropped
  function automatic tpl_adc_pkg::raw_sample_t lane_sample(
    input logic [`TPL_LINK_WIDTH-1:0] d,
    input int c,
    input int n
  );
    logic [SMP_BITS-1:0] word;

    word = {d[c*LANE_BITS + 16*n +: 8], d[c*LANE_BITS + 16*n + 8 +: 8]};
    return word[SMP_BITS-1 -: RES];
  endfunction

  // Expected DMA word for one beat under the given format controls
  function automatic logic [`TPL_DMA_WIDTH-1:0] expected_data(
    input logic [`TPL_LINK_WIDTH-1:0] d,
    input logic [NUM_CH-1:0] en,
    input logic [NUM_CH-1:0] se,
    input logic [NUM_CH-1:0] typ
  );
    tpl_adc_pkg::raw_sample_t r;
    tpl_adc_pkg::fmt_sample_t f;
    logic msb;
    logic [`TPL_DMA_WIDTH-1:0] out;

    out = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      for (int n = 0; n < NUM_SMP; n++) begin
        r = lane_sample(d, c, n);
        f = '0;
        f[RES-1:0] = r;
        if (en[c]) begin
          // Offset binary becomes two's complement by flipping the MSB
          msb = typ[c] ? r[RES-1] : ~r[RES-1];
          f[RES-1] = msb;
          if (se[c]) begin
            f[SMP_BITS-1:RES] = {(SMP_BITS-RES){msb}};
          end
        end
        out[(c*NUM_SMP + n)*SMP_BITS +: SMP_BITS] = f;
      end
    end
    return out;
  endfunction

  // Sample that follows prev in the PN stream
  // Bit 0 of the stream array is the oldest one. The window before prev is
  // taken as the parity of prev, which is how the 15-bit register is seeded
  function automatic tpl_adc_pkg::raw_sample_t pn_next(
    input tpl_adc_pkg::raw_sample_t prev,
    input logic pn15
  );
    logic [0:2*RES] s;
    tpl_adc_pkg::raw_sample_t nxt;

    s = '0;
    s[0] = ^prev;
    for (int i = 0; i < RES; i++) begin
      s[1+i] = prev[RES-1-i];
    end
    for (int t = RES + 1; t <= 2*RES; t++) begin
      // x^15+x^14+1 and x^7+x^6+1 as stream recurrences
      s[t] = pn15 ? (s[t-15] ^ s[t-14]) : (s[t-7] ^ s[t-6]);
    end
    for (int i = 0; i < RES; i++) begin
      nxt[RES-1-i] = s[RES+1+i];
    end
    return nxt;
  endfunction

  // PN status of channel c after the beat two edges back
  task automatic update_pn(input int c);
    tpl_adc_pkg::pn_sel_e sel;
    tpl_adc_pkg::raw_sample_t prev;
    tpl_adc_pkg::raw_sample_t s;
    logic bad;

    sel = tpl_adc_pkg::pn_sel_e'(h1.sel[4*c +: 4]);
    bad = 1'b0;
    prev = last[c];
    if (h2.valid) begin
      for (int n = 0; n < NUM_SMP; n++) begin
        s = lane_sample(h2.data, c, n);
        if (s != pn_next(prev, sel == tpl_adc_pkg::PN15))
          bad = 1'b1;
        prev = s;
      end
      last[c] = prev;
    end
    if (sel != tpl_adc_pkg::PN7 && sel != tpl_adc_pkg::PN15) begin
      exp_err[c] = 1'b0;
      exp_oos[c] = 1'b1;
      good_run[c] = 0;
      bad_run[c] = 0;
    end else if (h2.valid) begin
      exp_err[c] = bad;
      if (bad) begin
        good_run[c] = 0;
        if (bad_run[c] < LOCK)
          bad_run[c]++;
      end else begin
        bad_run[c] = 0;
        if (good_run[c] < LOCK)
          good_run[c]++;
      end
      // Sync state flips once a run of equal results is long enough
      if (exp_oos[c] && good_run[c] == LOCK)
        exp_oos[c] = 1'b0;
      else if (!exp_oos[c] && bad_run[c] == LOCK)
        exp_oos[c] = 1'b1;
    end
  endtask

  // ************************************************************************
  // Compare process
  // ************************************************************************

  // Outputs are read at the falling edge, half a cycle after they settle
  // h1 holds the inputs of the last falling edge and h2 those before it
  always @(negedge clk) begin
    cur = {link_valid, link_data, adc_sync, adc_sync_in, dfmt_enable,
           dfmt_sign_extend, dfmt_type, pn_seq_sel};
    if (!arst_n) begin
      h1 = '0;
      h2 = '0;
      exp_armed = 1'b0;
      exp_err = '0;
      exp_oos = '1;
      for (int c = 0; c < NUM_CH; c++) begin
        last[c] = '0;
        good_run[c] = 0;
        bad_run[c] = 0;
      end
    end else begin
      // A new rise of adc_sync toggles and takes priority over adc_sync_in
      if (h1.sync && !h2.sync)
        exp_armed = ~exp_armed;
      else if (h1.sync_in && !h2.sync_in)
        exp_armed = 1'b0;
      for (int c = 0; c < NUM_CH; c++) begin
        update_pn(c);
      end
      check_val("adc_valid", {NUM_CH{h2.valid}}, adc_valid);
      // The formatter sees the controls one edge after the link beat
      if (h2.valid)
        check_val("adc_data", expected_data(h2.data, h1.en, h1.se, h1.typ), adc_data);
      check_val("pn_err", exp_err, pn_err);
      check_val("pn_oos", exp_oos, pn_oos);
      check_val("adc_sync_armed", exp_armed, adc_sync_armed);
      h2 = h1;
      h1 = cur;
    end
  end

endmodule
